// File: rtl/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// filter geometry
`define FIR_TAP_NUM        11
`define FIR_DATA_WIDTH     32
`define FIR_ADDR_WIDTH     12

// configuration map, byte offsets
`define FIR_REG_AP_CTRL    12'h000    // bit 0 start, bit 1 done, bit 2 idle
`define FIR_REG_DATA_LEN   12'h010
`define FIR_REG_TAP_BASE   12'h040    // tap i at base + 4*i

// longest run the length register accepts
`define FIR_MAX_LEN        1023

`endif

// File: rtl/fir_ctrl_pkg.sv
package fir_ctrl_pkg;

    ////////////////////////////////////////
    // sequencer states

    typedef enum logic [2:0] {
        ST_INIT = 3'd0,    // zero the sample history
        ST_IDLE = 3'd1,
        ST_WAIT = 3'd2,    // waiting for an input sample
        ST_CALC = 3'd3,    // one tap per cycle
        ST_OUT  = 3'd4     // result waiting on sm_tready
    } seq_state_t;

    ////////////////////////////////////////
    // decoded configuration register

    typedef enum logic [1:0] {
        REG_AP_CTRL  = 2'd0,
        REG_DATA_LEN = 2'd1,
        REG_TAP      = 2'd2,
        REG_NONE     = 2'd3
    } reg_sel_t;

endpackage

// File: rtl/fir_data_pkg.sv
`include "fir_cfg.svh"

package fir_data_pkg;

    // samples and coefficients share one width
    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_DATA_WIDTH-1:0] coef_t;

    // tap and history index, 0 to 10
    typedef logic [3:0] tap_idx_t;

    // sample count of one run
    typedef logic [9:0] len_t;

endpackage

// File: rtl/fir_cfg_regs.sv
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_cfg_regs (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0]  wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  araddr,
    output logic                        arready,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`FIR_DATA_WIDTH-1:0]  rdata,
    input  logic                        seq_idle,
    input  logic                        run_done,
    input  fir_data_pkg::tap_idx_t      tap_idx,
    output fir_data_pkg::coef_t         tap_coef,
    output logic                        ap_start_pulse,
    output fir_data_pkg::len_t          data_len
);
    import fir_ctrl_pkg::*;
    import fir_data_pkg::*;

    coef_t    taps [`FIR_TAP_NUM];
    logic     ap_done;        // sticky until an ap_ctrl read
    logic     wr_hs;
    logic     rd_hs;
    reg_sel_t wr_sel;
    reg_sel_t rd_sel;
    tap_idx_t wr_tap;
    tap_idx_t rd_tap;

    function automatic reg_sel_t decode(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        reg_sel_t sel;
        if (addr == `FIR_REG_AP_CTRL) begin
            sel = REG_AP_CTRL;
        end else if (addr == `FIR_REG_DATA_LEN) begin
            sel = REG_DATA_LEN;
        end else if (addr >= `FIR_REG_TAP_BASE && addr[1:0] == 2'b00 &&
                     addr < `FIR_REG_TAP_BASE + 4 * `FIR_TAP_NUM) begin
            sel = REG_TAP;
        end else begin
            sel = REG_NONE;
        end
        return sel;
    endfunction

    function automatic tap_idx_t tap_of(input logic [`FIR_ADDR_WIDTH-1:0] addr);
        logic [`FIR_ADDR_WIDTH-1:0] offs;
        offs = addr - `FIR_REG_TAP_BASE;
        return offs[5:2];    // word offset from the tap base
    endfunction

    ////////////////////////////////////////
    // write side, address and data together

    assign awready = awvalid & wvalid;
    assign wready  = awvalid & wvalid;
    assign wr_hs   = awvalid & wvalid;
    assign wr_sel  = decode(awaddr);
    assign wr_tap  = tap_of(awaddr);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_len       <= '0;
            ap_start_pulse <= 1'b0;
        end else begin
            ap_start_pulse <= wr_hs && wr_sel == REG_AP_CTRL && wdata[0] && seq_idle;
            if (wr_hs && wr_sel == REG_DATA_LEN) begin
                data_len <= (wdata > `FIR_MAX_LEN) ? len_t'(`FIR_MAX_LEN) : wdata[9:0];
            end
        end
    end

    // coefficients only change between runs
    always_ff @(posedge axis_clk) begin
        if (wr_hs && wr_sel == REG_TAP && seq_idle) begin
            taps[wr_tap] <= coef_t'(wdata);
        end
    end

    assign tap_coef = taps[tap_idx];

    ////////////////////////////////////////
    // read side

    assign arready = ~rvalid;    // one read in flight
    assign rd_hs   = arvalid & arready;
    assign rd_sel  = decode(araddr);
    assign rd_tap  = tap_of(araddr);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rvalid  <= 1'b0;
            ap_done <= 1'b0;
        end else begin
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (run_done) begin
                ap_done <= 1'b1;
            end else if (rd_hs && rd_sel == REG_AP_CTRL) begin
                ap_done <= 1'b0;    // read clears done
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_hs) begin
            case (rd_sel)
                REG_AP_CTRL:  rdata <= {{(`FIR_DATA_WIDTH-3){1'b0}},
                                        seq_idle, ap_done, ap_start_pulse};
                REG_DATA_LEN: rdata <= {{(`FIR_DATA_WIDTH-10){1'b0}}, data_len};
                REG_TAP:      rdata <= taps[rd_tap];
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

// File: rtl/fir_sample_buffer.sv
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_sample_buffer (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    wr_en,
    input  fir_data_pkg::tap_idx_t  wr_ptr,
    input  fir_data_pkg::sample_t   wr_data,
    input  fir_data_pkg::tap_idx_t  rd_idx,
    output fir_data_pkg::sample_t   rd_data
);
    import fir_data_pkg::*;

    // ring of the newest samples, wr_ptr points past the newest
    sample_t hist [`FIR_TAP_NUM];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                hist[i] <= '0;
            end
        end else if (wr_en) begin
            hist[wr_ptr] <= wr_data;    // sample, or zero while clearing
        end
    end

    // read port feeds the multiplier in the same cycle
    assign rd_data = hist[rd_idx];

endmodule

// File: rtl/fir_sequencer.sv
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_sequencer (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    ap_start_pulse,
    input  fir_data_pkg::len_t      data_len,
    input  logic                    ss_tvalid,
    input  fir_data_pkg::sample_t   ss_tdata,
    output logic                    ss_tready,
    input  logic                    out_taken,
    output logic                    seq_idle,
    output logic                    run_done,
    output logic                    buf_wr_en,
    output fir_data_pkg::tap_idx_t  buf_wr_ptr,
    output fir_data_pkg::sample_t   buf_wr_data,
    output fir_data_pkg::tap_idx_t  buf_rd_idx,
    output fir_data_pkg::tap_idx_t  tap_idx,
    output logic                    mac_clear,
    output logic                    mac_valid,
    output logic                    mac_last
);
    import fir_ctrl_pkg::*;
    import fir_data_pkg::*;

    localparam tap_idx_t LAST_IDX = tap_idx_t'(`FIR_TAP_NUM - 1);

    seq_state_t state;
    seq_state_t state_nx;
    tap_idx_t   wr_ptr;
    len_t       sample_cnt;     // samples taken in this run
    logic       in_hs;
    logic       last_sample;

    function automatic tap_idx_t step_up(input tap_idx_t idx);
        return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    assign in_hs       = (state == ST_WAIT) && ss_tvalid;
    assign last_sample = (sample_cnt == data_len);

    ////////////////////////////////////////
    // state machine

    always_comb begin
        state_nx = state;
        case (state)
            ST_INIT: begin
                if (wr_ptr == LAST_IDX) begin
                    state_nx = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (ap_start_pulse) begin
                    state_nx = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (ss_tvalid) begin
                    state_nx = ST_CALC;
                end
            end
            ST_CALC: begin
                if (tap_idx == LAST_IDX) begin
                    state_nx = ST_OUT;
                end
            end
            ST_OUT: begin
                if (out_taken) begin
                    state_nx = last_sample ? ST_INIT : ST_WAIT;    // clear after the run
                end
            end
            default: state_nx = ST_INIT;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state      <= ST_INIT;
            wr_ptr     <= '0;
            buf_rd_idx <= '0;
            tap_idx    <= '0;
            sample_cnt <= '0;
        end else begin
            state <= state_nx;
            case (state)
                ST_INIT: wr_ptr <= step_up(wr_ptr);    // wraps back to 0 on exit
                ST_IDLE: sample_cnt <= '0;
                ST_WAIT: begin
                    if (ss_tvalid) begin
                        buf_rd_idx <= wr_ptr;    // newest sample pairs with tap 0
                        wr_ptr     <= step_up(wr_ptr);
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                ST_CALC: begin
                    tap_idx    <= step_up(tap_idx);
                    buf_rd_idx <= (buf_rd_idx == '0) ? LAST_IDX : buf_rd_idx - 1'b1;
                end
                ST_OUT: begin
                    if (out_taken && last_sample) begin
                        wr_ptr <= '0;
                    end
                end
                default: wr_ptr <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // outputs

    assign ss_tready   = (state == ST_WAIT);
    assign seq_idle    = (state == ST_IDLE);
    assign run_done    = (state == ST_OUT) && out_taken && last_sample;
    assign buf_wr_en   = (state == ST_INIT) || in_hs;
    assign buf_wr_ptr  = wr_ptr;
    assign buf_wr_data = (state == ST_INIT) ? '0 : ss_tdata;
    assign mac_valid   = (state == ST_CALC);
    assign mac_clear   = mac_valid && (tap_idx == '0);    // first tap restarts the sum
    assign mac_last    = mac_valid && last_sample;

endmodule

// File: rtl/fir_mac.sv
`timescale 1ns/10ps

module fir_mac (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    mac_clear,
    input  logic                    mac_valid,
    input  logic                    mac_last,
    input  fir_data_pkg::sample_t   sample,
    input  fir_data_pkg::coef_t     coef,
    input  logic                    sm_tready,
    output logic                    sm_tvalid,
    output logic                    sm_tlast,
    output fir_data_pkg::sample_t   sm_tdata,
    output logic                    out_taken
);
    import fir_data_pkg::*;

    sample_t prod_q;
    sample_t acc_q;
    logic    prod_vld;
    logic    prod_clr;
    logic    acc_vld;
    logic    last_q;       // this sample ends the run
    logic    acc_done;

    // the sum is complete once the last product has drained
    assign acc_done  = acc_vld && !prod_vld;
    assign out_taken = sm_tvalid && sm_tready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_vld <= 1'b0;
            prod_clr <= 1'b0;
            acc_vld  <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            prod_vld <= mac_valid;
            prod_clr <= mac_clear;
            acc_vld  <= prod_vld;
            if (mac_valid && mac_clear) begin
                last_q <= mac_last;
            end
        end
    end

    ////////////////////////////////////////
    // product and accumulator, wrap mod 2^32

    always_ff @(posedge axis_clk) begin
        if (mac_valid) begin
            prod_q <= sample * coef;
        end
        if (prod_vld) begin
            acc_q <= prod_clr ? prod_q : acc_q + prod_q;
        end
    end

    ////////////////////////////////////////
    // held stream output

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (acc_done) begin
            sm_tvalid <= 1'b1;
            sm_tlast  <= last_q;
        end else if (out_taken) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (acc_done) begin
            sm_tdata <= acc_q;
        end
    end

endmodule

// File: rtl/fir_top.sv
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_top (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // configuration slave
    input  logic                        awvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`FIR_DATA_WIDTH-1:0]  wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  logic [`FIR_ADDR_WIDTH-1:0]  araddr,
    output logic                        arready,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`FIR_DATA_WIDTH-1:0]  rdata,
    // stream in
    input  logic                        ss_tvalid,
    input  fir_data_pkg::sample_t       ss_tdata,
    output logic                        ss_tready,
    // stream out
    output logic                        sm_tvalid,
    output fir_data_pkg::sample_t       sm_tdata,
    output logic                        sm_tlast,
    input  logic                        sm_tready
);
    import fir_data_pkg::*;

    logic     ap_start_pulse;
    len_t     data_len;
    coef_t    tap_coef;
    tap_idx_t tap_idx;
    logic     seq_idle;
    logic     run_done;
    logic     buf_wr_en;
    tap_idx_t buf_wr_ptr;
    sample_t  buf_wr_data;
    tap_idx_t buf_rd_idx;
    sample_t  buf_rd_data;
    logic     mac_clear;
    logic     mac_valid;
    logic     mac_last;
    logic     out_taken;

    fir_cfg_regs u_cfg_regs (
        .axis_clk       (axis_clk),
        .axis_rst_n     (axis_rst_n),
        .awvalid        (awvalid),
        .awaddr         (awaddr),
        .awready        (awready),
        .wvalid         (wvalid),
        .wdata          (wdata),
        .wready         (wready),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arready        (arready),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .seq_idle       (seq_idle),
        .run_done       (run_done),
        .tap_idx        (tap_idx),
        .tap_coef       (tap_coef),
        .ap_start_pulse (ap_start_pulse),
        .data_len       (data_len)
    );

    fir_sample_buffer u_sample_buffer (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .wr_en      (buf_wr_en),
        .wr_ptr     (buf_wr_ptr),
        .wr_data    (buf_wr_data),
        .rd_idx     (buf_rd_idx),
        .rd_data    (buf_rd_data)
    );

    fir_sequencer u_sequencer (
        .axis_clk       (axis_clk),
        .axis_rst_n     (axis_rst_n),
        .ap_start_pulse (ap_start_pulse),
        .data_len       (data_len),
        .ss_tvalid      (ss_tvalid),
        .ss_tdata       (ss_tdata),
        .ss_tready      (ss_tready),
        .out_taken      (out_taken),
        .seq_idle       (seq_idle),
        .run_done       (run_done),
        .buf_wr_en      (buf_wr_en),
        .buf_wr_ptr     (buf_wr_ptr),
        .buf_wr_data    (buf_wr_data),
        .buf_rd_idx     (buf_rd_idx),
        .tap_idx        (tap_idx),
        .mac_clear      (mac_clear),
        .mac_valid      (mac_valid),
        .mac_last       (mac_last)
    );

    fir_mac u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .mac_clear  (mac_clear),
        .mac_valid  (mac_valid),
        .mac_last   (mac_last),
        .sample     (buf_rd_data),    // history and coefficient line up by tap
        .coef       (tap_coef),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata),
        .out_taken  (out_taken)
    );

endmodule

// File: tb/fir_assertions.sv
`timescale 1ns/10ps

module fir_assertions (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       ss_tvalid,
    input  logic                       ss_tready,
    input  logic                       sm_tvalid,
    input  logic                       sm_tready,
    input  logic                       sm_tlast,
    input  fir_data_pkg::sample_t      sm_tdata,
    input  logic                       rvalid,
    input  logic                       rready,
    input  fir_ctrl_pkg::seq_state_t   seq_state
);
    import fir_ctrl_pkg::*;

    int fail_cnt;    // failures seen by the properties below

    initial begin
        fail_cnt = 0;
    end

    ////////////////////////////////////////
    // stream side

    out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        $error("stream output changed or dropped before sm_tready");
        fail_cnt++;
    end

    no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid))
    else begin
        $error("ss_tready high while an output is pending");
        fail_cnt++;
    end

    // valid rises on the 13th edge after the input handshake
    out_latency: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tvalid && ss_tready |=> ##13 $rose(sm_tvalid))
    else begin
        $error("sm_tvalid did not rise 13 cycles after the input handshake");
        fail_cnt++;
    end

    // last output taken, 11 cycles of clearing, then idle
    clear_after_last: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && sm_tready && sm_tlast |=> seq_state == ST_INIT ##11 seq_state == ST_IDLE)
    else begin
        $error("history clearing after the last output did not take 11 cycles");
        fail_cnt++;
    end

    ////////////////////////////////////////
    // config read side

    read_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_cnt++;
    end

endmodule

bind fir_top fir_assertions fir_assertions_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tvalid  (ss_tvalid),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .seq_state  (u_sequencer.state)
);

// File: tb/fir_tb.sv
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_tb;
    import fir_data_pkg::*;

    // samples over all runs, each costs about 16 cycles, plus register traffic
    localparam int RUN_SAMPLES    = 11 + 40 + 40 + 15 + 15;
    localparam int TIMEOUT_CYCLES = 10 * (RUN_SAMPLES * 16 + 100);

    logic                       axis_clk;
    logic                       axis_rst_n;
    logic                       awvalid;
    logic [`FIR_ADDR_WIDTH-1:0] awaddr;
    logic                       awready;
    logic                       wvalid;
    logic [`FIR_DATA_WIDTH-1:0] wdata;
    logic                       wready;
    logic                       arvalid;
    logic [`FIR_ADDR_WIDTH-1:0] araddr;
    logic                       arready;
    logic                       rvalid;
    logic                       rready;
    logic [`FIR_DATA_WIDTH-1:0] rdata;
    logic                       ss_tvalid;
    sample_t                    ss_tdata;
    logic                       ss_tready;
    logic                       sm_tvalid;
    sample_t                    sm_tdata;
    logic                       sm_tlast;
    logic                       sm_tready;

    logic [15:0] lfsr;
    logic [31:0] tap_ref [`FIR_TAP_NUM];    // taps as last written while idle
    logic [31:0] stim_q [$];
    logic [31:0] got_data_q [$];
    logic        got_last_q [$];
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          cycle_cnt;

    fir_top fir_top_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    always #50 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // random numbers and reference model

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // y[n] = sum tap[k] * x[n-k], wrapping, zero before the run
    function automatic logic [31:0] fir_expect(input int n);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < `FIR_TAP_NUM; k++) begin
            if (n - k >= 0) begin
                acc = acc + tap_ref[k] * stim_q[n - k];
            end
        end
        return acc;
    endfunction

    function automatic logic [`FIR_ADDR_WIDTH-1:0] tap_addr(input int i);
        return `FIR_ADDR_WIDTH'(`FIR_REG_TAP_BASE + 4 * i);
    endfunction

    ////////////////////////////////////////
    // bus tasks

    task automatic axil_write(input logic [`FIR_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge axis_clk);
        while (!(awready && wready)) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);    // write lands on this edge
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [`FIR_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge axis_clk);
        while (!arready) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        @(negedge axis_clk);
        while (!rvalid) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);    // response waits one cycle on rready
        #1;
        rready = 1'b1;
        @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        assert (got === exp) else begin
            $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wait_idle(output logic [31:0] ctrl);
        int polls;
        polls = 0;
        ctrl  = '0;
        while (!ctrl[2] && polls < 40) begin
            axil_read(`FIR_REG_AP_CTRL, ctrl);
            polls++;
        end
        check_cnt++;
        assert (ctrl[2]) else begin
            $display("ap_idle did not rise within %0d register reads", polls);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // stream tasks

    task automatic start_run(input int len);
        axil_write(`FIR_REG_DATA_LEN, len);
        axil_write(`FIR_REG_AP_CTRL, 32'd1);
    endtask

    task automatic feed_samples();
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge axis_clk);
            #1;
            ss_tvalid = 1'b1;
            ss_tdata  = stim_q[i];
            @(negedge axis_clk);
            while (!ss_tready) begin
                @(negedge axis_clk);
            end
        end
        @(posedge axis_clk);
        #1;
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input logic gated);
        while (got_data_q.size() < stim_q.size()) begin
            @(posedge axis_clk);
            #1;
            sm_tready = gated ? rand_bits(1) != '0 : 1'b1;
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin    // taken on the coming edge
                got_data_q.push_back(sm_tdata);
                got_last_q.push_back(sm_tlast);
            end
        end
        // stay ready a while longer, an extra output would show up here
        repeat (`FIR_TAP_NUM + 4) begin
            @(posedge axis_clk);
            #1;
            sm_tready = 1'b1;
            @(negedge axis_clk);
            if (sm_tvalid) begin
                got_data_q.push_back(sm_tdata);
                got_last_q.push_back(sm_tlast);
            end
        end
        @(posedge axis_clk);
        #1;
        sm_tready = 1'b0;
    endtask

    task automatic stream_run(input logic gated);
        got_data_q.delete();
        got_last_q.delete();
        fork
            feed_samples();
            collect_outputs(gated);
        join
    endtask

    task automatic fill_random(input int n);
        stim_q.delete();
        repeat (n) begin
            stim_q.push_back(rand_bits(32));
        end
    endtask

    task automatic check_outputs();
        check_eq(got_data_q.size(), stim_q.size(), "output count");
        for (int i = 0; i < got_data_q.size(); i++) begin
            check_eq(got_data_q[i], fir_expect(i), $sformatf("output %0d", i));
            check_eq(got_last_q[i], i == stim_q.size() - 1, $sformatf("tlast on output %0d", i));
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %-18s %0d errors", name, err_cnt - errs_before);
    endtask

    ////////////////////////////////////////
    // tests

    task automatic test_regs();
        logic [31:0] rd;
        int          errs;
        errs = err_cnt;
        wait_idle(rd);
        check_eq(rd[1], 1'b0, "ap_done after reset");
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            tap_ref[i] = rand_bits(32);
            axil_write(tap_addr(i), tap_ref[i]);
        end
        axil_write(`FIR_REG_DATA_LEN, 32'd37);
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            axil_read(tap_addr(i), rd);
            check_eq(rd, tap_ref[i], $sformatf("tap %0d readback", i));
        end
        axil_read(`FIR_REG_DATA_LEN, rd);
        check_eq(rd, 32'd37, "data length readback");
        axil_write(`FIR_REG_DATA_LEN, 32'd5000);    // beyond the limit
        axil_read(`FIR_REG_DATA_LEN, rd);
        check_eq(rd, `FIR_MAX_LEN, "data length clamp");
        axil_read(12'h024, rd);
        check_eq(rd, '0, "unmapped address");
        end_test("reset_and_regs", errs);
    endtask

    task automatic test_impulse();
        logic [31:0] rd;
        int          errs;
        errs = err_cnt;
        stim_q.delete();
        stim_q.push_back(32'd1);
        repeat (`FIR_TAP_NUM - 1) begin
            stim_q.push_back(32'd0);
        end
        start_run(`FIR_TAP_NUM);
        stream_run(1'b0);
        check_eq(got_data_q.size(), `FIR_TAP_NUM, "impulse output count");
        for (int i = 0; i < got_data_q.size(); i++) begin
            check_eq(got_data_q[i], tap_ref[i], $sformatf("impulse output %0d", i));
            check_eq(got_last_q[i], i == `FIR_TAP_NUM - 1, $sformatf("impulse tlast %0d", i));
        end
        wait_idle(rd);
        end_test("impulse", errs);
    endtask

    task automatic test_random_stream();
        logic [31:0] rd;
        int          errs;
        errs = err_cnt;
        fill_random(40);
        start_run(40);
        stream_run(1'b0);
        check_outputs();
        wait_idle(rd);
        end_test("random_stream", errs);
    endtask

    // same samples as the previous test, sink stalls at random
    task automatic test_backpressure();
        logic [31:0] rd;
        int          errs;
        errs = err_cnt;
        start_run(stim_q.size());
        stream_run(1'b1);
        check_outputs();
        wait_idle(rd);
        end_test("backpressure", errs);
    endtask

    task automatic test_done_and_restart();
        logic [31:0] rd;
        int          errs;
        errs = err_cnt;
        fill_random(15);
        start_run(15);
        stream_run(1'b1);
        check_outputs();
        axil_read(`FIR_REG_AP_CTRL, rd);
        check_eq(rd[1], 1'b1, "ap_done after run");
        axil_read(`FIR_REG_AP_CTRL, rd);
        check_eq(rd[1], 1'b0, "ap_done after second read");
        wait_idle(rd);
        fill_random(15);
        start_run(15);
        axil_read(`FIR_REG_AP_CTRL, rd);
        check_eq(rd[2], 1'b0, "ap_idle during run");
        axil_write(tap_addr(0), ~tap_ref[0]);    // busy, so the old tap stays
        axil_read(tap_addr(0), rd);
        check_eq(rd, tap_ref[0], "tap 0 after write during run");
        stream_run(1'b0);
        check_outputs();    // fresh history, old taps
        wait_idle(rd);
        end_test("done_and_restart", errs);
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        lfsr       = 16'd61683;
        err_cnt    = 0;
        check_cnt  = 0;
        test_cnt   = 0;
        cycle_cnt  = 0;
        repeat (16) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        test_regs();
        test_impulse();
        test_random_stream();
        test_backpressure();
        test_done_and_restart();

        err_cnt = err_cnt + fir_top_i.fir_assertions_i.fail_cnt;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 test_cnt, check_cnt, fir_top_i.fir_assertions_i.fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/fir_ctrl_pkg.sv
rtl/fir_data_pkg.sv
rtl/fir_cfg_regs.sv
rtl/fir_sample_buffer.sv
rtl/fir_sequencer.sv
rtl/fir_mac.sv
rtl/fir_top.sv
tb/fir_assertions.sv
tb/fir_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the FIR testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fir_tb -f list.f -o Vfir_tb

# let assertion errors pile up so the testbench can report them itself
./obj_dir/Vfir_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation log is clean"
